// ==== rtl/soc_map_pkg.sv ====
package soc_map_pkg;

  // Address map of the SoC memory side
  localparam logic [31:0] uart_base     = 32'h1000_0000;
  localparam logic [31:0] uart_size     = 32'h0000_1000;
  localparam logic [31:0] rtc_addr      = 32'h0200_BFF8;
  localparam logic [31:0] rtc_addr_high = 32'h0200_BFFC;
  localparam logic [31:0] flash_base    = 32'h3000_0000;
  localparam logic [31:0] flash_size    = 32'h1000_0000;
  localparam logic [31:0] sram_base     = 32'h0F00_0000;
  localparam logic [31:0] sram_size     = 32'h0000_2000;
  localparam logic [31:0] psram_base    = 32'h8000_0000;
  localparam logic [31:0] psram_size    = 32'h2000_0000;
  localparam logic [31:0] sdram_base    = 32'hA000_0000;
  localparam logic [31:0] sdram_size    = 32'h2000_0000;
  localparam logic [31:0] gpio_base     = 32'h1000_2000;
  localparam logic [31:0] gpio_size     = 32'h0000_0010;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef enum logic [2:0] {
    zone_other  = 3'd0,
    zone_psram  = 3'd1,
    zone_sram   = 3'd2,
    zone_uart   = 3'd3,
    zone_rtc    = 3'd4,
    zone_flash  = 3'd5,
    zone_sdram  = 3'd6,
    zone_device = 3'd7
  } mem_zone_e;

  // Handshake states shared by both AXI-Lite slaves
  typedef enum logic {
    rd_idle,
    rd_resp
  } rd_state_e;

  typedef enum logic {
    wr_idle,
    wr_resp
  } wr_state_e;

  // UART and GPIO both count as device space
  function automatic mem_zone_e addr_zone(input logic [31:0] addr);
    mem_zone_e zone;
    if (addr >= uart_base && addr < uart_base + uart_size) begin
      zone = zone_device;
    end else if (addr == rtc_addr || addr == rtc_addr_high) begin
      zone = zone_rtc;
    end else if (addr >= flash_base && addr < flash_base + flash_size) begin
      zone = zone_flash;
    end else if (addr >= sram_base && addr < sram_base + sram_size) begin
      zone = zone_sram;
    end else if (addr >= psram_base && addr < psram_base + psram_size) begin
      zone = zone_psram;
    end else if (addr >= sdram_base && addr < sdram_base + sdram_size) begin
      zone = zone_sdram;
    end else if (addr >= gpio_base && addr < gpio_base + gpio_size) begin
      zone = zone_device;
    end else begin
      zone = zone_other;
    end
    return zone;
  endfunction

  function automatic logic [31:0] strb_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== rtl/axi_lite_xbar.sv ====
`timescale 1ns/1ps

module axi_lite_xbar (
  // Master side from the bus arbiter
  input  logic        m_arvalid,
  output logic        m_arready,
  input  logic [31:0] m_araddr,
  output logic        m_rvalid,
  input  logic        m_rready,
  output logic [31:0] m_rdata,
  output logic [1:0]  m_rresp,
  input  logic        m_awvalid,
  output logic        m_awready,
  input  logic [31:0] m_awaddr,
  input  logic        m_wvalid,
  output logic        m_wready,
  input  logic [31:0] m_wdata,
  input  logic [3:0]  m_wstrb,
  output logic        m_bvalid,
  input  logic        m_bready,
  output logic [1:0]  m_bresp,

  // Timer side
  output logic        t_arvalid,
  input  logic        t_arready,
  output logic [31:0] t_araddr,
  input  logic        t_rvalid,
  output logic        t_rready,
  input  logic [31:0] t_rdata,
  input  logic [1:0]  t_rresp,
  output logic        t_awvalid,
  input  logic        t_awready,
  output logic [31:0] t_awaddr,
  output logic        t_wvalid,
  input  logic        t_wready,
  output logic [31:0] t_wdata,
  output logic [3:0]  t_wstrb,
  input  logic        t_bvalid,
  output logic        t_bready,
  input  logic [1:0]  t_bresp,

  // Memory side
  output logic        s_arvalid,
  input  logic        s_arready,
  output logic [31:0] s_araddr,
  input  logic        s_rvalid,
  output logic        s_rready,
  input  logic [31:0] s_rdata,
  input  logic [1:0]  s_rresp,
  output logic        s_awvalid,
  input  logic        s_awready,
  output logic [31:0] s_awaddr,
  output logic        s_wvalid,
  input  logic        s_wready,
  output logic [31:0] s_wdata,
  output logic [3:0]  s_wstrb,
  input  logic        s_bvalid,
  output logic        s_bready,
  input  logic [1:0]  s_bresp,

  output logic        high,
  output logic        diff_skip
);

  soc_map_pkg::mem_zone_e read_zone;
  soc_map_pkg::mem_zone_e write_zone;
  logic                   read_to_timer;
  logic                   write_to_timer;

  assign read_zone  = soc_map_pkg::addr_zone(m_araddr);
  assign write_zone = soc_map_pkg::addr_zone(m_awaddr);

  assign read_to_timer  = (read_zone == soc_map_pkg::zone_rtc);
  assign write_to_timer = (write_zone == soc_map_pkg::zone_rtc);

  // The timer latches this on its address transfer to pick the mtime half
  assign high = (m_araddr == soc_map_pkg::rtc_addr_high);

  assign diff_skip = (read_zone == soc_map_pkg::zone_device)
                  || (write_zone == soc_map_pkg::zone_device)
                  || read_to_timer || write_to_timer;

  always_comb begin
    t_arvalid = 1'b0;
    t_rready  = 1'b0;
    t_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    s_araddr  = '0;
    if (read_to_timer) begin
      t_arvalid = m_arvalid;
      t_rready  = m_rready;
      t_araddr  = m_araddr;
      m_arready = t_arready;
      m_rvalid  = t_rvalid;
      m_rdata   = t_rdata;
      m_rresp   = t_rresp;
    end else begin
      s_arvalid = m_arvalid;
      s_rready  = m_rready;
      s_araddr  = m_araddr;
      m_arready = s_arready;
      m_rvalid  = s_rvalid;
      m_rdata   = s_rdata;
      m_rresp   = s_rresp;
    end
  end

  always_comb begin
    t_awvalid = 1'b0;
    t_wvalid  = 1'b0;
    t_bready  = 1'b0;
    t_awaddr  = '0;
    t_wdata   = '0;
    t_wstrb   = '0;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_awaddr  = '0;
    s_wdata   = '0;
    s_wstrb   = '0;
    if (write_to_timer) begin
      t_awvalid = m_awvalid;
      t_wvalid  = m_wvalid;
      t_bready  = m_bready;
      t_awaddr  = m_awaddr;
      t_wdata   = m_wdata;
      t_wstrb   = m_wstrb;
      m_awready = t_awready;
      m_wready  = t_wready;
      m_bvalid  = t_bvalid;
      m_bresp   = t_bresp;
    end else begin
      s_awvalid = m_awvalid;
      s_wvalid  = m_wvalid;
      s_bready  = m_bready;
      s_awaddr  = m_awaddr;
      s_wdata   = m_wdata;
      s_wstrb   = m_wstrb;
      m_awready = s_awready;
      m_wready  = s_wready;
      m_bvalid  = s_bvalid;
      m_bresp   = s_bresp;
    end
  end

endmodule

// ==== rtl/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        high
);

  soc_map_pkg::rd_state_e rd_state;
  soc_map_pkg::wr_state_e wr_state;
  logic [63:0]            mtime;
  logic [31:0]            wr_half;
  logic [31:0]            wr_merged;
  logic                   rd_fire;
  logic                   wr_fire;

  assign arready = (rd_state == soc_map_pkg::rd_idle);
  assign rvalid  = (rd_state == soc_map_pkg::rd_resp);
  assign rd_fire = arvalid && arready;

  // Address and data are taken together in one cycle
  assign wr_fire = awvalid && wvalid && (wr_state == soc_map_pkg::wr_idle);
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bvalid  = (wr_state == soc_map_pkg::wr_resp);

  assign wr_half   = awaddr[2] ? mtime[63:32] : mtime[31:0];
  assign wr_merged = soc_map_pkg::strb_merge(wr_half, wdata, wstrb);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= soc_map_pkg::rd_idle;
    end else if (rd_fire) begin
      rd_state <= soc_map_pkg::rd_resp;
    end else if (rvalid && rready) begin
      rd_state <= soc_map_pkg::rd_idle;
    end
  end

  // Snapshot of the requested half so a stalled response stays stable
  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rdata <= high ? mtime[63:32] : mtime[31:0];
      rresp <= (araddr[31:3] == soc_map_pkg::rtc_addr[31:3]) ?
               soc_map_pkg::resp_okay : soc_map_pkg::resp_slverr;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= soc_map_pkg::wr_idle;
    end else if (wr_fire) begin
      wr_state <= soc_map_pkg::wr_resp;
    end else if (bvalid && bready) begin
      wr_state <= soc_map_pkg::wr_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      bresp <= (awaddr[31:3] == soc_map_pkg::rtc_addr[31:3]) ?
               soc_map_pkg::resp_okay : soc_map_pkg::resp_slverr;
    end
  end

  // A landing write replaces the tick for that cycle
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= '0;
    end else if (wr_fire && awaddr[2]) begin
      mtime[63:32] <= wr_merged;
    end else if (wr_fire) begin
      mtime[31:0] <= wr_merged;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

endmodule

// ==== rtl/sram_slave.sv ====
`timescale 1ns/1ps

module sram_slave #(
  parameter int sram_depth_words = 1024
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp
);

  localparam int idx_w = $clog2(sram_depth_words);

  soc_map_pkg::rd_state_e rd_state;
  soc_map_pkg::wr_state_e wr_state;
  logic [31:0]            mem [sram_depth_words];
  logic [idx_w-1:0]       rd_idx;
  logic [idx_w-1:0]       wr_idx;
  logic                   rd_fire;
  logic                   wr_fire;

  // Only the low word-address bits index the array, so every zone aliases in
  assign rd_idx = araddr[idx_w+1:2];
  assign wr_idx = awaddr[idx_w+1:2];

  assign arready = (rd_state == soc_map_pkg::rd_idle);
  assign rvalid  = (rd_state == soc_map_pkg::rd_resp);
  assign rd_fire = arvalid && arready;

  assign wr_fire = awvalid && wvalid && (wr_state == soc_map_pkg::wr_idle);
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bvalid  = (wr_state == soc_map_pkg::wr_resp);

  assign rresp = soc_map_pkg::resp_okay;
  assign bresp = soc_map_pkg::resp_okay;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= soc_map_pkg::rd_idle;
    end else if (rd_fire) begin
      rd_state <= soc_map_pkg::rd_resp;
    end else if (rvalid && rready) begin
      rd_state <= soc_map_pkg::rd_idle;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= soc_map_pkg::wr_idle;
    end else if (wr_fire) begin
      wr_state <= soc_map_pkg::wr_resp;
    end else if (bvalid && bready) begin
      wr_state <= soc_map_pkg::wr_idle;
    end
  end

  // Read data is captured once and held through any rready stall
  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rdata <= mem[rd_idx];
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem[wr_idx] <= soc_map_pkg::strb_merge(mem[wr_idx], wdata, wstrb);
    end
  end

endmodule

// ==== rtl/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top #(
  parameter int sram_depth_words = 1024
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        m_arvalid,
  output logic        m_arready,
  input  logic [31:0] m_araddr,
  output logic        m_rvalid,
  input  logic        m_rready,
  output logic [31:0] m_rdata,
  output logic [1:0]  m_rresp,
  input  logic        m_awvalid,
  output logic        m_awready,
  input  logic [31:0] m_awaddr,
  input  logic        m_wvalid,
  output logic        m_wready,
  input  logic [31:0] m_wdata,
  input  logic [3:0]  m_wstrb,
  output logic        m_bvalid,
  input  logic        m_bready,
  output logic [1:0]  m_bresp,
  output logic        diff_skip
);

  logic        t_arvalid;
  logic        t_arready;
  logic [31:0] t_araddr;
  logic        t_rvalid;
  logic        t_rready;
  logic [31:0] t_rdata;
  logic [1:0]  t_rresp;
  logic        t_awvalid;
  logic        t_awready;
  logic [31:0] t_awaddr;
  logic        t_wvalid;
  logic        t_wready;
  logic [31:0] t_wdata;
  logic [3:0]  t_wstrb;
  logic        t_bvalid;
  logic        t_bready;
  logic [1:0]  t_bresp;

  logic        s_arvalid;
  logic        s_arready;
  logic [31:0] s_araddr;
  logic        s_rvalid;
  logic        s_rready;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        s_awvalid;
  logic        s_awready;
  logic [31:0] s_awaddr;
  logic        s_wvalid;
  logic        s_wready;
  logic [31:0] s_wdata;
  logic [3:0]  s_wstrb;
  logic        s_bvalid;
  logic        s_bready;
  logic [1:0]  s_bresp;

  logic        high;

  axi_lite_xbar xbar_i (
    .m_arvalid (m_arvalid), .m_arready (m_arready), .m_araddr (m_araddr),
    .m_rvalid  (m_rvalid),  .m_rready  (m_rready),  .m_rdata  (m_rdata),
    .m_rresp   (m_rresp),   .m_awvalid (m_awvalid), .m_awready (m_awready),
    .m_awaddr  (m_awaddr),  .m_wvalid  (m_wvalid),  .m_wready  (m_wready),
    .m_wdata   (m_wdata),   .m_wstrb   (m_wstrb),   .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),  .m_bresp   (m_bresp),
    .t_arvalid (t_arvalid), .t_arready (t_arready), .t_araddr (t_araddr),
    .t_rvalid  (t_rvalid),  .t_rready  (t_rready),  .t_rdata  (t_rdata),
    .t_rresp   (t_rresp),   .t_awvalid (t_awvalid), .t_awready (t_awready),
    .t_awaddr  (t_awaddr),  .t_wvalid  (t_wvalid),  .t_wready  (t_wready),
    .t_wdata   (t_wdata),   .t_wstrb   (t_wstrb),   .t_bvalid  (t_bvalid),
    .t_bready  (t_bready),  .t_bresp   (t_bresp),
    .s_arvalid (s_arvalid), .s_arready (s_arready), .s_araddr (s_araddr),
    .s_rvalid  (s_rvalid),  .s_rready  (s_rready),  .s_rdata  (s_rdata),
    .s_rresp   (s_rresp),   .s_awvalid (s_awvalid), .s_awready (s_awready),
    .s_awaddr  (s_awaddr),  .s_wvalid  (s_wvalid),  .s_wready  (s_wready),
    .s_wdata   (s_wdata),   .s_wstrb   (s_wstrb),   .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),  .s_bresp   (s_bresp),
    .high      (high),
    .diff_skip (diff_skip)
  );

  clint_timer timer_i (
    .clock   (clock),     .arst_n  (arst_n),
    .arvalid (t_arvalid), .arready (t_arready), .araddr (t_araddr),
    .rvalid  (t_rvalid),  .rready  (t_rready),  .rdata  (t_rdata),
    .rresp   (t_rresp),   .awvalid (t_awvalid), .awready (t_awready),
    .awaddr  (t_awaddr),  .wvalid  (t_wvalid),  .wready  (t_wready),
    .wdata   (t_wdata),   .wstrb   (t_wstrb),   .bvalid  (t_bvalid),
    .bready  (t_bready),  .bresp   (t_bresp),   .high    (high)
  );

  sram_slave #(
    .sram_depth_words (sram_depth_words)
  ) sram_i (
    .clock   (clock),     .arst_n  (arst_n),
    .arvalid (s_arvalid), .arready (s_arready), .araddr (s_araddr),
    .rvalid  (s_rvalid),  .rready  (s_rready),  .rdata  (s_rdata),
    .rresp   (s_rresp),   .awvalid (s_awvalid), .awready (s_awready),
    .awaddr  (s_awaddr),  .wvalid  (s_wvalid),  .wready  (s_wready),
    .wdata   (s_wdata),   .wstrb   (s_wstrb),   .bvalid  (s_bvalid),
    .bready  (s_bready),  .bresp   (s_bresp)
  );

endmodule

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

  localparam int sram_words  = 1024;
  localparam int fields      = 7;
  localparam int max_vectors = 64;

  logic        clock;
  logic        arst_n;
  logic        m_arvalid;
  logic        m_arready;
  logic [31:0] m_araddr;
  logic        m_rvalid;
  logic        m_rready;
  logic [31:0] m_rdata;
  logic [1:0]  m_rresp;
  logic        m_awvalid;
  logic        m_awready;
  logic [31:0] m_awaddr;
  logic        m_wvalid;
  logic        m_wready;
  logic [31:0] m_wdata;
  logic [3:0]  m_wstrb;
  logic        m_bvalid;
  logic        m_bready;
  logic [1:0]  m_bresp;
  logic        diff_skip;

  logic [31:0] vec_mem [max_vectors*fields];
  integer      seed;
  int          num_vectors;
  int          cycle_count;
  int          cycle_limit;
  int          check_count;
  int          error_count;

  mem_subsystem_top #(
    .sram_depth_words (sram_words)
  ) dut_i (
    .clock     (clock),     .arst_n    (arst_n),
    .m_arvalid (m_arvalid), .m_arready (m_arready), .m_araddr (m_araddr),
    .m_rvalid  (m_rvalid),  .m_rready  (m_rready),  .m_rdata  (m_rdata),
    .m_rresp   (m_rresp),   .m_awvalid (m_awvalid), .m_awready (m_awready),
    .m_awaddr  (m_awaddr),  .m_wvalid  (m_wvalid),  .m_wready  (m_wready),
    .m_wdata   (m_wdata),   .m_wstrb   (m_wstrb),   .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),  .m_bresp   (m_bresp),   .diff_skip (diff_skip)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
               $time, what, actual, expected);
    end
  endtask

  // The address stays on the bus until the response is taken, since it steers the crossbar
  task automatic axi_read(input logic [31:0] addr, input logic exp_skip,
                          output logic [31:0] data, output logic [1:0] resp);
    int stall;
    @(posedge clock);
    #1;
    m_arvalid = 1'b1;
    m_araddr  = addr;
    @(negedge clock);
    check_value(32'(diff_skip), 32'(exp_skip), $sformatf("diff_skip on read of %h", addr));
    while (!m_arready) begin
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    m_arvalid = 1'b0;
    @(negedge clock);
    check_value(32'(m_rvalid), 32'd1, "rvalid not one cycle after address transfer");
    check_value(32'(m_arready), 32'd0, "arready high while read response pending");
    while (!m_rvalid) begin
      @(negedge clock);
    end
    data  = m_rdata;
    resp  = m_rresp;
    stall = $random(seed) & 3;
    repeat (stall) begin
      @(negedge clock);
      check_value(32'(m_rvalid), 32'd1, "rvalid dropped during rready stall");
      check_value(m_rdata, data, "rdata changed during rready stall");
    end
    @(posedge clock);
    #1;
    m_rready = 1'b1;
    @(negedge clock);
    check_value(32'(m_rvalid), 32'd1, "rvalid low when rready raised");
    check_value(m_rdata, data, "rdata changed before transfer");
    @(posedge clock);
    #1;
    m_rready = 1'b0;
    m_araddr = 32'd0;
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic exp_skip,
                           output logic [1:0] resp);
    int stall;
    @(posedge clock);
    #1;
    m_awvalid = 1'b1;
    m_awaddr  = addr;
    m_wvalid  = 1'b1;
    m_wdata   = data;
    m_wstrb   = strb;
    @(negedge clock);
    check_value(32'(diff_skip), 32'(exp_skip), $sformatf("diff_skip on write to %h", addr));
    while (!(m_awready && m_wready)) begin
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    m_awvalid = 1'b0;
    m_wvalid  = 1'b0;
    @(negedge clock);
    check_value(32'(m_bvalid), 32'd1, "bvalid not one cycle after write transfer");
    while (!m_bvalid) begin
      @(negedge clock);
    end
    resp  = m_bresp;
    stall = $random(seed) & 3;
    repeat (stall) begin
      @(negedge clock);
      check_value(32'(m_bvalid), 32'd1, "bvalid dropped during bready stall");
      check_value(32'(m_bresp), 32'(resp), "bresp changed during bready stall");
    end
    @(posedge clock);
    #1;
    m_bready = 1'b1;
    @(negedge clock);
    check_value(32'(m_bvalid), 32'd1, "bvalid low when bready raised");
    @(posedge clock);
    #1;
    m_bready = 1'b0;
    m_awaddr = 32'd0;
    m_wdata  = 32'd0;
    m_wstrb  = 4'd0;
  endtask

  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] strb;
    logic [31:0] exp_data;
    logic [31:0] exp_skip;
    logic [31:0] mode;
    logic [31:0] rdata;
    logic [1:0]  resp;
    logic        in_range;

    clock       = 1'b0;
    arst_n      = 1'b0;
    m_arvalid   = 1'b0;
    m_araddr    = 32'd0;
    m_rready    = 1'b0;
    m_awvalid   = 1'b0;
    m_awaddr    = 32'd0;
    m_wvalid    = 1'b0;
    m_wdata     = 32'd0;
    m_wstrb     = 4'd0;
    m_bready    = 1'b0;
    seed        = 82427;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    cycle_limit = max_vectors * 12 + 100;

    $readmemh("verification/mem_vectors.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < max_vectors && vec_mem[num_vectors*fields] != 32'hff) begin
      num_vectors++;
    end
    if (num_vectors == max_vectors) begin
      $display("Vector file has no end marker within %0d vectors", max_vectors);
      error_count++;
    end
    cycle_limit = num_vectors * 12 + 100;

    repeat (8) @(posedge clock);
    #1;
    arst_n = 1'b1;
    @(negedge clock);
    check_value(32'(m_rvalid), 32'd0, "rvalid after reset");
    check_value(32'(m_bvalid), 32'd0, "bvalid after reset");
    check_value(32'(m_arready), 32'd1, "arready after reset");
    check_value(32'(m_awready), 32'd0, "awready after reset");
    check_value(32'(m_wready), 32'd0, "wready after reset");

    for (int i = 0; i < num_vectors; i++) begin
      op       = vec_mem[i*fields];
      addr     = vec_mem[i*fields+1];
      wdata    = vec_mem[i*fields+2];
      strb     = vec_mem[i*fields+3];
      exp_data = vec_mem[i*fields+4];
      exp_skip = vec_mem[i*fields+5];
      mode     = vec_mem[i*fields+6];
      if (op == 32'd1) begin
        axi_write(addr, wdata, strb[3:0], exp_skip[0], resp);
        check_value(32'(resp), 32'(soc_map_pkg::resp_okay),
                    $sformatf("bresp of write to %h", addr));
      end else begin
        axi_read(addr, exp_skip[0], rdata, resp);
        check_value(32'(resp), 32'(soc_map_pkg::resp_okay),
                    $sformatf("rresp of read from %h", addr));
        if (mode == 32'd0) begin
          check_value(rdata, exp_data, $sformatf("read data from %h", addr));
        end else if (mode == 32'd2) begin
          // mtime low keeps counting, so only a short window after the write is allowed
          in_range = (rdata >= exp_data) && (rdata < exp_data + 32'd40);
          check_value(32'(in_range), 32'd1,
                      $sformatf("mtime low %h outside window from %h", rdata, exp_data));
        end
      end
    end

    $display("Ran %0d vectors, %0d checks, %0d errors", num_vectors, check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/soc_map_pkg.sv
rtl/axi_lite_xbar.sv
rtl/clint_timer.sv
rtl/sram_slave.sv
rtl/mem_subsystem_top.sv
verification/mem_subsystem_tb.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= mem_subsystem_tb
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG      ?= sim.log
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/mem_vectors.txt ====
// Columns: op addr wdata strb rdata skip mode, all hex
// op 1 write, 0 read, ff end; mode 0 exact data, 1 no data, 2 mtime low range
1 0F000010 11223344 f 00000000 0 1
0 0F000010 00000000 0 11223344 0 0
1 0F000010 AABBCCDD 5 00000000 0 1
0 0F000010 00000000 0 11BB33DD 0 0
1 30000100 55667788 f 00000000 0 1
1 30000100 FFEEDDCC a 00000000 0 1
0 30000100 00000000 0 FF66DD88 0 0
1 80000200 99AABBCC f 00000000 0 1
0 80000200 00000000 0 99AABBCC 0 0
1 A0000300 0F1E2D3C f 00000000 0 1
0 A0000300 00000000 0 0F1E2D3C 0 0
0 80000300 00000000 0 0F1E2D3C 0 0
1 10000040 12345678 f 00000000 1 1
0 10000040 00000000 0 12345678 1 0
1 10002004 87654321 f 00000000 1 1
0 10002004 00000000 0 87654321 1 0
1 00001000 0BADC0DE f 00000000 0 1
0 00000000 00000000 0 0BADC0DE 0 0
1 0200BFF8 00001000 f 00000000 1 1
1 0200BFFC 000000AB f 00000000 1 1
0 0200BFFC 00000000 0 000000AB 1 0
0 0200BFF8 00000000 0 00001000 1 2
1 0200BFF8 00003000 f 00000000 1 1
1 0F001FF8 CAFEF00D f 00000000 0 1
0 0200BFF8 00000000 0 00003000 1 2
0 0F001FF8 00000000 0 CAFEF00D 0 0
1 0200BFF8 00005000 f 00000000 1 1
0 0F001FF8 00000000 0 CAFEF00D 0 0
ff 00000000 00000000 0 00000000 0 0
